//--- testbench/conv_layer_patterns.txt
# hex Q8.8 words in two lines per pixel
# first line holds mem_data words 0 to 15
# second line holds skip_data words 0 to 3 then expected filter_out 0 to 3
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
0000 0000 0000 0000 0010 0020 0030 0040
0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100 0100
0000 0000 0000 0000 0010 1020 2030 3040
0000 0001 0002 0003 0004 0005 0006 0007 0008 0009 000A 000B 000C 000D 000E 000F
0001 0002 0003 0004 004D 00D6 015F 01E8
FF00 FF00 FF00 FF00 FF00 FF00 FF00 FF00 FF00 FF00 FF00 FF00 FF00 FF00 FF00 FF00
FFF0 FFF0 FFF0 FFF0 0000 F010 E020 D030
7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF
7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF 7FFF
8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000 8000
8000 8000 8000 8000 8010 8000 8000 8000
0000 0000 0000 0100 0000 0000 0000 0000 0000 0000 0000 0000 0200 0000 0000 0000
0000 FF00 0080 F000 0310 0520 09B0 FC40
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
7FF0 7FF0 7FF0 7FF0 7FFF 7FFF 7FFF 7FFF
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0000
7FE0 7FE0 7FE0 7FE0 7FF0 7FFF 7FFF 7FFF

//--- conv_layer.f
hdl/conv_layer_pkg.sv
hdl/conv_ctrl_pkg.sv
hdl/layer_controller.sv
hdl/coef_rom.sv
hdl/slice_feeder.sv
hdl/mac_lane.sv
hdl/skip_adder.sv
hdl/conv_layer.sv
testbench/conv_layer_properties.sv
testbench/conv_layer_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the conv_layer testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --timescale 1ns/1ps \
  --top-module conv_layer_tb \
  --Mdir obj_dir \
  -o conv_layer_sim \
  -f conv_layer.f

./obj_dir/conv_layer_sim +verilator+error+limit+100 | tee sim.log

if grep -q "CHECKS FAILED" sim.log; then
  echo "simulation reported errors, see sim.log"
  exit 1
fi
echo "simulation finished without errors"

//--- testbench/conv_layer_tb.sv
`timescale 1ns/1ps

module conv_layer_tb
  import conv_layer_pkg::*;
();

  localparam int lanes    = 4;
  localparam int addr_w   = 10;
  // start edge to the edge where out_valid is taken
  localparam int latency  = 7;
  localparam int wait_max = 20;
  localparam int max_pat  = 16;
  localparam int mem_n    = depth_n * slice_n;

  logic              clk;
  logic              reset;
  logic              start;
  data_word          mem_data [mem_n];
  data_word          skip_data [lanes];
  logic [addr_w-1:0] mem_addr;
  logic [addr_w-1:0] skip_addr;
  logic [addr_w-1:0] out_addr;
  data_word          filter_out [lanes];
  logic              out_valid;
  logic              busy;

  // pattern store filled from the data file
  data_word pat_mem  [max_pat][mem_n];
  data_word pat_skip [max_pat][lanes];
  data_word pat_exp  [max_pat][lanes];
  int       n_pat;

  int                error_cnt;
  int                check_cnt;
  int                test_cnt;
  int                test_err0;
  int                assert_cnt;
  // address the next finished pixel should carry
  logic [addr_w-1:0] next_addr;
  integer            seed;

  conv_layer #(
    .lanes(lanes),
    .addr_w(addr_w)
  ) conv_layer_i (
    .clk(clk),
    .reset(reset),
    .start(start),
    .mem_data(mem_data),
    .skip_data(skip_data),
    .mem_addr(mem_addr),
    .skip_addr(skip_addr),
    .out_addr(out_addr),
    .filter_out(filter_out),
    .out_valid(out_valid),
    .busy(busy)
  );

  bind conv_layer conv_layer_properties props_i (
    .clk(clk),
    .reset(reset),
    .start(start),
    .busy(busy),
    .slice_valid(slice_valid),
    .out_valid(out_valid)
  );

  // 10 ns clock
  initial clk = 1'b0;
  always #5 clk = ~clk;

  task automatic check_filter(input string name, input data_word exp, input data_word act);
    check_cnt++;
    if (act !== exp)
    begin
      error_cnt++;
      $display("[FAIL] %0t %s expected %0d got %0d", $time, name, exp, act);
    end
  endtask

  task automatic check_addr(input string name, input logic [addr_w-1:0] exp,
                            input logic [addr_w-1:0] act);
    check_cnt++;
    if (act !== exp)
    begin
      error_cnt++;
      $display("[FAIL] %0t %s expected %0d got %0d", $time, name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    check_cnt++;
    if (act !== exp)
    begin
      error_cnt++;
      $display("[FAIL] %0t %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  // cycle count from start to the result
  task automatic check_latency(input string name, input int exp, input int act);
    check_cnt++;
    if (act != exp)
    begin
      error_cnt++;
      $display("[FAIL] %0t %s expected %0d got %0d", $time, name, exp, act);
    end
  endtask

  task automatic begin_test();
    test_err0 = error_cnt;
  endtask

  task automatic end_test(input string name);
    test_cnt++;
    if (error_cnt == test_err0)
      $display("test %0d %s: ok", test_cnt, name);
    else
      $display("test %0d %s: %0d errors", test_cnt, name, error_cnt - test_err0);
  endtask

  // next line that is neither a comment nor blank
  task automatic next_data_line(input int fd, output string line, output bit found);
    string raw;
    int    code;
    found = 1'b0;
    line  = "";
    while (!found && !$feof(fd))
    begin
      code = $fgets(raw, fd);
      if (code > 1 && raw.substr(0, 0) != "#")
      begin
        line  = raw;
        found = 1'b1;
      end
    end
  endtask

  // mem words on one line and skip plus expected words on the next
  task automatic load_patterns();
    int    fd;
    int    cnt;
    string line;
    bit    found;
    n_pat = 0;
    fd = $fopen("testbench/conv_layer_patterns.txt", "r");
    if (fd == 0)
    begin
      error_cnt++;
      $display("could not open the pattern file");
    end
    else
    begin
      found = 1'b1;
      while (found && n_pat < max_pat)
      begin
        next_data_line(fd, line, found);
        if (found)
        begin
          cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
            pat_mem[n_pat][0], pat_mem[n_pat][1], pat_mem[n_pat][2], pat_mem[n_pat][3],
            pat_mem[n_pat][4], pat_mem[n_pat][5], pat_mem[n_pat][6], pat_mem[n_pat][7],
            pat_mem[n_pat][8], pat_mem[n_pat][9], pat_mem[n_pat][10], pat_mem[n_pat][11],
            pat_mem[n_pat][12], pat_mem[n_pat][13], pat_mem[n_pat][14], pat_mem[n_pat][15]);
          next_data_line(fd, line, found);
          if (found)
            cnt += $sscanf(line, "%h %h %h %h %h %h %h %h",
              pat_skip[n_pat][0], pat_skip[n_pat][1], pat_skip[n_pat][2], pat_skip[n_pat][3],
              pat_exp[n_pat][0], pat_exp[n_pat][1], pat_exp[n_pat][2], pat_exp[n_pat][3]);
          if (cnt == mem_n + 2 * lanes)
          begin
            n_pat++;
          end
          else
          begin
            error_cnt++;
            $display("pattern %0d in the data file is incomplete", n_pat);
            found = 1'b0;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic wait_idle();
    int cycles;
    cycles = 0;
    while (busy && cycles < wait_max)
    begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (busy)
    begin
      error_cnt++;
      $display("busy still high %0d cycles after the result", wait_max);
    end
  endtask

  // no result may show up and the address must hold
  task automatic expect_quiet(input int n);
    repeat (n)
    begin
      @(posedge clk);
      #1;
      check_flag("out_valid", 1'b0, out_valid);
    end
    check_addr("mem_addr", next_addr, mem_addr);
  endtask

  // one pixel pass with an optional second start while busy
  task automatic run_pixel(input int p, input int gap, input bit busy_start);
    int cycles;
    bit seen;
    repeat (gap)
    begin
      @(posedge clk);
      #1;
    end
    for (int j = 0; j < mem_n; j++)
      mem_data[j] = pat_mem[p][j];
    for (int i = 0; i < lanes; i++)
      skip_data[i] = pat_skip[p][i];
    start = 1'b1;
    // edge 0 takes the start
    @(posedge clk);
    #1;
    start  = 1'b0;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < wait_max)
    begin
      // extra start taken at edge 3 in mid pass
      start = busy_start && (cycles == 2);
      @(posedge clk);
      #1;
      cycles++;
      seen = out_valid;
    end
    start = 1'b0;
    if (!seen)
    begin
      error_cnt++;
      $display("no out_valid within %0d cycles of start for pattern %0d", wait_max, p);
    end
    else
    begin
      // seen just after the edge that set it and taken at the next one
      check_latency("out_valid latency", latency, cycles + 1);
      for (int i = 0; i < lanes; i++)
        check_filter($sformatf("filter_out[%0d]", i), pat_exp[p][i], filter_out[i]);
      check_addr("out_addr", next_addr, out_addr);
      check_addr("skip_addr", next_addr, skip_addr);
      next_addr++;
      // single cycle pulse
      @(posedge clk);
      #1;
      check_flag("out_valid", 1'b0, out_valid);
      wait_idle();
      check_addr("mem_addr", next_addr, mem_addr);
    end
  endtask

  initial
  begin
    seed      = 39191;
    error_cnt = 0;
    check_cnt = 0;
    test_cnt  = 0;
    next_addr = '0;
    reset     = 1'b1;
    start     = 1'b0;
    for (int j = 0; j < mem_n; j++)
      mem_data[j] = '0;
    for (int i = 0; i < lanes; i++)
      skip_data[i] = '0;
    load_patterns();

    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;

    begin_test();
    check_flag("busy", 1'b0, busy);
    check_flag("out_valid", 1'b0, out_valid);
    check_addr("out_addr", '0, out_addr);
    check_addr("mem_addr", '0, mem_addr);
    end_test("reset state");

    // every pattern with a random idle gap
    for (int p = 0; p < n_pat; p++)
    begin
      begin_test();
      run_pixel(p, $unsigned($random(seed)) % 4, 1'b0);
      end_test($sformatf("pattern %0d", p));
    end

    if (n_pat < 7)
    begin
      error_cnt++;
      $display("only %0d patterns loaded, at least 7 are needed", n_pat);
    end
    else
    begin
      begin_test();
      run_pixel(2, 1, 1'b1);
      expect_quiet(10);
      end_test("start while busy");

      // negative sums then zeros so the result must be bias only
      begin_test();
      run_pixel(3, 0, 1'b0);
      run_pixel(0, 0, 1'b0);
      run_pixel(6, 0, 1'b0);
      run_pixel(1, 0, 1'b0);
      end_test("back-to-back starts");
    end

    assert_cnt = int'(conv_layer_i.props_i.assert_errors);
    $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
             test_cnt, check_cnt, error_cnt, assert_cnt);
    if (error_cnt == 0 && assert_cnt == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

//--- testbench/conv_layer_properties.sv
`timescale 1ns/1ps

module conv_layer_properties
(
  input logic clk,
  input logic reset,
  input logic start,
  input logic busy,
  input logic slice_valid,
  input logic out_valid
);

  // failing assertion count
  int unsigned assert_errors = 0;

  // start taken from idle, one result seven edges on
  a_start_to_valid: assert property (
    @(posedge clk) disable iff (reset)
    (start && !busy) |-> ##7 out_valid
  )
  else
  begin
    assert_errors++;
    $error("out_valid did not follow start by 7 cycles");
  end

  // four slices per pass, then a gap
  a_slice_len: assert property (
    @(posedge clk) disable iff (reset)
    $rose(slice_valid) |-> slice_valid ##1 slice_valid ##1 slice_valid ##1 slice_valid
      ##1 !slice_valid
  )
  else
  begin
    assert_errors++;
    $error("slice_valid did not last exactly four cycles");
  end

  // controller idle once reset is seen
  a_idle_after_reset: assert property (
    @(posedge clk)
    reset |=> !busy
  )
  else
  begin
    assert_errors++;
    $error("busy high after reset");
  end

endmodule

//--- hdl/conv_layer.sv
`timescale 1ns/1ps

module conv_layer
  import conv_layer_pkg::*;
  import conv_ctrl_pkg::*;
#(
  parameter int lanes  = 4,
  parameter int addr_w = 10
)
(
  input  logic              clk,
  input  logic              reset,
  input  logic              start,
  input  data_word          mem_data [depth_n*slice_n],
  input  data_word          skip_data [lanes],
  output logic [addr_w-1:0] mem_addr,
  output logic [addr_w-1:0] skip_addr,
  output logic [addr_w-1:0] out_addr,
  output data_word          filter_out [lanes],
  output logic              out_valid,
  output logic              busy
);

  // controller to feeder and rom
  depth_idx depth;
  logic     slice_strobe;
  // feeder to lanes
  data_word slice_data [slice_n];
  logic     slice_valid;
  logic     slice_first;
  logic     slice_last;
  // rom to lanes
  data_word weights [lanes][slice_n];
  data_word bias    [lanes];
  // lanes to skip adder
  acc_word  acc      [lanes];
  logic     acc_done [lanes];

  layer_controller #(
    .addr_w(addr_w)
  ) ctrl_i (
    .clk(clk),
    .reset(reset),
    .start(start),
    .busy(busy),
    .slice_strobe(slice_strobe),
    .depth(depth),
    .mem_addr(mem_addr),
    .skip_addr(skip_addr),
    .out_addr(out_addr)
  );

  coef_rom #(
    .lanes(lanes)
  ) rom_i (
    .clk(clk),
    .depth(depth),
    .slice_strobe(slice_strobe),
    .weights(weights),
    .bias(bias)
  );

  slice_feeder feeder_i (
    .clk(clk),
    .reset(reset),
    .slice_strobe(slice_strobe),
    .depth(depth),
    .mem_data(mem_data),
    .slice_data(slice_data),
    .slice_valid(slice_valid),
    .slice_first(slice_first),
    .slice_last(slice_last)
  );

  // one lane per output filter, all see the same slice
  for (genvar i = 0; i < lanes; i++)
  begin : g_lane
    mac_lane lane_i (
      .clk(clk),
      .reset(reset),
      .slice_valid(slice_valid),
      .slice_first(slice_first),
      .slice_last(slice_last),
      .slice_data(slice_data),
      .weights(weights[i]),
      .bias(bias[i]),
      .acc(acc[i]),
      .acc_done(acc_done[i])
    );
  end

  // lanes run in lockstep, lane 0 done stands for all
  skip_adder #(
    .lanes(lanes)
  ) skip_i (
    .clk(clk),
    .reset(reset),
    .acc(acc),
    .acc_done(acc_done[0]),
    .skip_data(skip_data),
    .filter_out(filter_out),
    .out_valid(out_valid)
  );

endmodule

//--- hdl/skip_adder.sv
`timescale 1ns/1ps

module skip_adder
  import conv_layer_pkg::*;
#(
  parameter int lanes = 4
)
(
  input  logic     clk,
  input  logic     reset,
  input  acc_word  acc [lanes],
  input  logic     acc_done,
  input  data_word skip_data [lanes],
  output data_word filter_out [lanes],
  output logic     out_valid
);

  // signed 16-bit limits
  localparam acc_word sat_max = acc_word'(2 ** (data_w - 1) - 1);
  localparam acc_word sat_min = acc_word'(-(2 ** (data_w - 1)));

  acc_word  sum_w [lanes];
  data_word sat_w [lanes];

  always_comb
  begin
    for (int i = 0; i < lanes; i++)
    begin
      // back to Q8.8, then residual add
      sum_w[i] = (acc[i] >>> frac_bits) + acc_word'(skip_data[i]);
      // clamp to the sample range
      if (sum_w[i] > sat_max)
        sat_w[i] = data_word'(sat_max);
      else if (sum_w[i] < sat_min)
        sat_w[i] = data_word'(sat_min);
      else
        sat_w[i] = data_word'(sum_w[i]);
    end
  end

  // result held until the next pixel
  always_ff @(posedge clk)
  begin
    if (acc_done)
    begin
      filter_out <= sat_w;
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
      out_valid <= 1'b0;
    else
      out_valid <= acc_done;
  end

endmodule

//--- hdl/mac_lane.sv
`timescale 1ns/1ps

module mac_lane
  import conv_layer_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     slice_valid,
  input  logic     slice_first,
  input  logic     slice_last,
  input  data_word slice_data [slice_n],
  input  data_word weights    [slice_n],
  input  data_word bias,
  output acc_word  acc,
  output logic     acc_done
);

  // dot product of the current slice
  acc_word slice_sum;
  // bias moved up to product scale, Q8.8 * Q8.8 = Q.16
  acc_word bias_ext;

  always_comb
  begin
    slice_sum = '0;
    for (int k = 0; k < slice_n; k++)
    begin
      // signed operands, sign extended to accumulator width
      slice_sum = slice_sum + slice_data[k] * weights[k];
    end
  end

  assign bias_ext = acc_word'(bias) <<< frac_bits;

  // first slice restarts from bias, no carry over from the last pixel
  always_ff @(posedge clk)
  begin
    if (slice_valid)
    begin
      if (slice_first)
      begin
        acc <= bias_ext + slice_sum;
      end
      else
      begin
        acc <= acc + slice_sum;
      end
    end
  end

  // done one cycle after the last slice, acc is final then
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      acc_done <= 1'b0;
    end
    else
    begin
      acc_done <= slice_valid && slice_last;
    end
  end

endmodule

//--- hdl/slice_feeder.sv
`timescale 1ns/1ps

module slice_feeder
  import conv_layer_pkg::*;
  import conv_ctrl_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     slice_strobe,
  input  depth_idx depth,
  input  data_word mem_data [depth_n*slice_n],
  output data_word slice_data [slice_n],
  output logic     slice_valid,
  output logic     slice_first,
  output logic     slice_last
);

  // slice words, base at 4 * depth
  always_ff @(posedge clk)
  begin
    if (slice_strobe)
    begin
      for (int k = 0; k < slice_n; k++)
      begin
        slice_data[k] <= mem_data[int'(depth) * slice_n + k];
      end
    end
  end

  // strobes delayed to match the data
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      slice_valid <= 1'b0;
      slice_first <= 1'b0;
      slice_last  <= 1'b0;
    end
    else
    begin
      slice_valid <= slice_strobe;
      slice_first <= slice_strobe && (depth == '0);
      slice_last  <= slice_strobe && (depth == depth_idx'(depth_n - 1));
    end
  end

endmodule

//--- hdl/coef_rom.sv
`timescale 1ns/1ps

module coef_rom
  import conv_layer_pkg::*;
  import conv_ctrl_pkg::*;
#(
  parameter int lanes = 4
)
(
  input  logic     clk,
  input  depth_idx depth,
  input  logic     slice_strobe,
  output data_word weights [lanes][slice_n],
  output data_word bias    [lanes]
);

  // bias step per filter, raw Q8.8 units
  localparam int bias_step = 16;

  // weight(f, d, k) = f + d - k in Q8.8
  // loaded with the slice so it lines up with the feeder output
  always_ff @(posedge clk)
  begin
    if (slice_strobe)
    begin
      for (int f = 0; f < lanes; f++)
      begin
        for (int k = 0; k < slice_n; k++)
        begin
          weights[f][k] <= data_word'((f + int'(depth) - k) <<< frac_bits);
        end
      end
    end
  end

  // biases do not depend on depth
  always_comb
  begin
    for (int f = 0; f < lanes; f++)
    begin
      bias[f] = data_word'(bias_step * (f + 1));
    end
  end

endmodule

//--- hdl/layer_controller.sv
`timescale 1ns/1ps

module layer_controller
  import conv_layer_pkg::*;
  import conv_ctrl_pkg::*;
#(
  parameter int addr_w = 10
)
(
  input  logic              clk,
  input  logic              reset,
  input  logic              start,
  output logic              busy,
  output logic              slice_strobe,
  output depth_idx          depth,
  output logic [addr_w-1:0] mem_addr,
  output logic [addr_w-1:0] skip_addr,
  output logic [addr_w-1:0] out_addr
);

  // last slice of a pass
  localparam depth_idx last_depth = depth_idx'(depth_n - 1);
  // drain covers feeder, lane and skip adder stages, three cycles
  localparam depth_idx last_drain = depth_idx'(2);

  ctrl_state         state;
  depth_idx          depth_cnt;
  logic [addr_w-1:0] pixel_cnt;
  logic [addr_w-1:0] pass_addr;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state     <= st_idle;
      depth_cnt <= '0;
      pixel_cnt <= '0;
      pass_addr <= '0;
    end
    else
    begin
      case (state)
        st_idle:
        begin
          depth_cnt <= '0;
          // start only honoured here, so a start while busy is dropped
          if (start)
          begin
            state     <= st_run;
            pass_addr <= pixel_cnt;
          end
        end
        st_run:
        begin
          // one slice per cycle, wraps to 0 for the drain count
          depth_cnt <= depth_cnt + 1'b1;
          if (depth_cnt == last_depth)
          begin
            state <= st_drain;
          end
        end
        st_drain:
        begin
          if (depth_cnt == last_drain)
          begin
            state     <= st_idle;
            depth_cnt <= '0;
            // pixel done, move to next address
            pixel_cnt <= pixel_cnt + 1'b1;
          end
          else
          begin
            depth_cnt <= depth_cnt + 1'b1;
          end
        end
        default:
        begin
          state <= st_idle;
        end
      endcase
    end
  end

  assign busy         = (state != st_idle);
  assign slice_strobe = (state == st_run);
  assign depth        = depth_cnt;

  // input memory follows the live counter
  assign mem_addr  = pixel_cnt;
  // skip and output address latched at pass start
  assign skip_addr = pass_addr;
  assign out_addr  = pass_addr;

endmodule

//--- hdl/conv_ctrl_pkg.sv
// controller state and depth counter types
package conv_ctrl_pkg;

  // pixel pass sequence
  typedef enum logic [1:0] {
    st_idle,
    st_run,
    st_drain
  } ctrl_state;

  // depth slice index 0..3, doubles as drain counter
  typedef logic [1:0] depth_idx;

endpackage

//--- hdl/conv_layer_pkg.sv
// datapath sizes and word types for the 1x1 conv stage
package conv_layer_pkg;

  // sample width in bits
  localparam int data_w = 16;
  // depth slices per output pixel
  localparam int depth_n = 4;
  // words per depth slice
  localparam int slice_n = 4;
  // accumulator width, room for 16 products plus the shifted bias
  localparam int acc_w = 40;
  // Q8.8 fraction bits
  localparam int frac_bits = 8;

  // signed Q8.8 sample
  typedef logic signed [data_w-1:0] data_word;
  // signed accumulator, Q24.16 after products
  typedef logic signed [acc_w-1:0] acc_word;

endpackage
